//--- Bender.yml
package:
  name: batch_stream

sources:
  - include_dirs:
      - .
    files:
      - stream_beat_pkg.sv
      - stream_ctrl_pkg.sv
      - sample_tagger.sv
      - moderating_fifo.sv
      - credit_sender.sv
      - batch_stream_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - batch_stream_props.sv
      - tb_batch_stream_top.sv

//--- batch_stream_defines.svh
// Sizing macros shared by the whole batch stream path.
// Include this header in any package or module that needs a width,
// a depth or a credit pool size. BATCH_LEN must not exceed FIFO_DEPTH.
`ifndef BATCH_STREAM_DEFINES_SVH
`define BATCH_STREAM_DEFINES_SVH

// Width of one converter sample
`define DATA_W 16
// Width of the destination channel number
`define DEST_W 4
// Width of the running sequence number carried in the user field
`define USER_W 16

// Slots in the moderating FIFO, also the tagger's starting credit
`define FIFO_DEPTH 16
// Beats released per batch
`define BATCH_LEN 8
// Accepted samples per packet, sets the period of the last flag
`define PACKET_LEN 4

// Credits granted by the sink after reset
`define SINK_CREDITS 4
// Entries in the sender buffer, the FIFO's starting credit toward it
`define SENDER_SLOTS 2

`endif

//--- batch_stream_props.sv
// Concurrent checks on one credit-spending stage of the batch stream path.
// Bound into the moderating FIFO and the credit sender. The credit pool of
// a stage never grows past the credits it started with, and a credit comes
// back only for a beat still outstanding. With BATCH above zero the stage
// must also send exactly BATCH beats in each release phase.
`timescale 1ns/1ps

module batch_stream_props #(
    parameter int POOL  = 2,
    parameter int BATCH = 0
) (
    input logic                           clock,
    input logic                           rst_n,
    input stream_ctrl_pkg::credit_count_t credits,
    input logic                           spend,
    input logic                           credit_back,
    input logic                           in_release
);

    // Number of failed checks
    int fail_count = 0;

    // The pool never holds more credits than it was granted
    credits_bounded: assert property (
        @(posedge clock) disable iff (!rst_n) int'(credits) <= POOL
    ) else begin
        fail_count++;
        $error("credit count above its pool");
    end

    // A returned credit always belongs to a beat still outstanding
    return_fits_pool: assert property (
        @(posedge clock) disable iff (!rst_n) credit_back |-> (int'(credits) < POOL)
    ) else begin
        fail_count++;
        $error("credit returned into a full pool");
    end

    // Batch length checks apply only to a stage that releases in batches
    if (BATCH > 0) begin : g_batch
        // Beats sent so far in the current release phase
        int sent_in_batch;

        always_ff @(posedge clock or negedge rst_n) begin
            if (!rst_n) begin
                sent_in_batch <= 0;
            end else if (!in_release) begin
                sent_in_batch <= 0;
            end else if (spend) begin
                sent_in_batch <= sent_in_batch + 1;
            end
        end

        // No release phase sends more than one batch
        batch_not_exceeded: assert property (
            @(posedge clock) disable iff (!rst_n) in_release |-> (sent_in_batch < BATCH)
        ) else begin
            fail_count++;
            $error("release phase sent more than one batch");
        end

        // A release phase ends only after a whole batch has left
        batch_complete: assert property (
            @(posedge clock) disable iff (!rst_n)
            $fell(in_release) |-> (sent_in_batch == BATCH)
        ) else begin
            fail_count++;
            $error("release phase ended before a whole batch was sent");
        end
    end

endmodule

//--- batch_stream_top.f
+incdir+.
stream_beat_pkg.sv
stream_ctrl_pkg.sv
sample_tagger.sv
moderating_fifo.sv
credit_sender.sv
batch_stream_top.sv
batch_stream_props.sv
tb_batch_stream_top.sv

//--- batch_stream_top.sv
// Top level of the batch stream path: tagger, moderating FIFO and
// credit sender in a chain. The converter input has no flow control;
// the sink link uses credits granted through out_credit.
`timescale 1ns/1ps

module batch_stream_top (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         sample_valid,
    input  stream_beat_pkg::sample_t     sample,
    input  stream_beat_pkg::dest_t       channel,
    output logic                         out_valid,
    output stream_beat_pkg::sample_t     out_data,
    output stream_beat_pkg::dest_t       out_dest,
    output stream_beat_pkg::seq_t        out_user,
    output logic                         out_last,
    input  logic                         out_credit,
    output stream_ctrl_pkg::drop_count_t drop_count
);
    import stream_beat_pkg::*;

    // Tagger to FIFO link
    logic    tag_valid;
    sample_t tag_data;
    dest_t   tag_dest;
    seq_t    tag_user;
    logic    tag_last;
    logic    tag_credit;

    // FIFO to sender link
    logic    rel_valid;
    sample_t rel_data;
    dest_t   rel_dest;
    seq_t    rel_user;
    logic    rel_last;
    logic    rel_credit;

    sample_tagger u_tagger (
        .clock(clock), .rst_n(rst_n),
        .sample_valid(sample_valid), .sample(sample), .channel(channel),
        .tag_credit(tag_credit), .tag_valid(tag_valid), .tag_data(tag_data),
        .tag_dest(tag_dest), .tag_user(tag_user), .tag_last(tag_last),
        .drop_count(drop_count)
    );

    moderating_fifo u_fifo (
        .clock(clock), .rst_n(rst_n),
        .tag_valid(tag_valid), .tag_data(tag_data), .tag_dest(tag_dest),
        .tag_user(tag_user), .tag_last(tag_last), .tag_credit(tag_credit),
        .rel_valid(rel_valid), .rel_data(rel_data), .rel_dest(rel_dest),
        .rel_user(rel_user), .rel_last(rel_last), .rel_credit(rel_credit)
    );

    credit_sender u_sender (
        .clock(clock), .rst_n(rst_n),
        .rel_valid(rel_valid), .rel_data(rel_data), .rel_dest(rel_dest),
        .rel_user(rel_user), .rel_last(rel_last), .rel_credit(rel_credit),
        .out_valid(out_valid), .out_data(out_data), .out_dest(out_dest),
        .out_user(out_user), .out_last(out_last), .out_credit(out_credit)
    );

endmodule

//--- credit_sender.sv
// Output stage of the batch stream path.
// A small buffer of SENDER_SLOTS entries takes every beat from the FIFO and
// forwards the oldest one to the sink whenever a sink credit is held. With
// an empty buffer a beat goes straight through to the output register.
// Each beat sent out returns one credit to the FIFO.
`timescale 1ns/1ps
`include "batch_stream_defines.svh"

module credit_sender (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     rel_valid,
    input  stream_beat_pkg::sample_t rel_data,
    input  stream_beat_pkg::dest_t   rel_dest,
    input  stream_beat_pkg::seq_t    rel_user,
    input  logic                     rel_last,
    output logic                     rel_credit,
    output logic                     out_valid,
    output stream_beat_pkg::sample_t out_data,
    output stream_beat_pkg::dest_t   out_dest,
    output stream_beat_pkg::seq_t    out_user,
    output logic                     out_last,
    input  logic                     out_credit
);
    import stream_beat_pkg::*;
    import stream_ctrl_pkg::*;

    sample_t data_buf [`SENDER_SLOTS];
    dest_t   dest_buf [`SENDER_SLOTS];
    seq_t    user_buf [`SENDER_SLOTS];
    logic    last_buf [`SENDER_SLOTS];

    slot_addr_t    wr_slot;
    slot_addr_t    rd_slot;
    // Beats waiting in the buffer
    credit_count_t slot_count;
    // Credits granted by the sink and not yet spent
    credit_count_t sink_credits;
    logic          buf_empty;
    logic          send;
    logic          bypass;
    logic          store;
    logic          pop;

    function automatic slot_addr_t next_slot(input slot_addr_t slot);
        if (slot == slot_addr_t'(`SENDER_SLOTS - 1)) begin
            return '0;
        end
        return slot + slot_addr_t'(1);
    endfunction

    assign buf_empty = (slot_count == '0);
    assign send      = (sink_credits != '0) && (!buf_empty || rel_valid);
    // The incoming beat skips the buffer only when nothing older waits
    assign bypass    = send && buf_empty;
    assign store     = rel_valid && !bypass;
    assign pop       = send && !buf_empty;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_slot      <= '0;
            rd_slot      <= '0;
            slot_count   <= '0;
            sink_credits <= credit_count_t'(`SINK_CREDITS);
            out_valid    <= 1'b0;
            rel_credit   <= 1'b0;
        end else begin
            out_valid    <= send;
            rel_credit   <= send;
            sink_credits <= sink_credits + credit_count_t'(out_credit) - credit_count_t'(send);
            slot_count   <= slot_count + credit_count_t'(store) - credit_count_t'(pop);
            if (store) begin
                wr_slot <= next_slot(wr_slot);
            end
            if (pop) begin
                rd_slot <= next_slot(rd_slot);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (store) begin
            data_buf[wr_slot] <= rel_data;
            dest_buf[wr_slot] <= rel_dest;
            user_buf[wr_slot] <= rel_user;
            last_buf[wr_slot] <= rel_last;
        end
    end

    // Output beat register
    always_ff @(posedge clock) begin
        if (bypass) begin
            out_data <= rel_data;
            out_dest <= rel_dest;
            out_user <= rel_user;
            out_last <= rel_last;
        end else if (pop) begin
            out_data <= data_buf[rd_slot];
            out_dest <= dest_buf[rd_slot];
            out_user <= user_buf[rd_slot];
            out_last <= last_buf[rd_slot];
        end
    end

endmodule

//--- moderating_fifo.sv
// Moderating FIFO between the tagger and the credit sender.
// Beats are stored in arrival order and held back until BATCH_LEN of them
// are present. Then exactly BATCH_LEN beats are released, one per cycle
// while sender credit lasts, before the FIFO goes back to collecting.
// Every released beat returns one credit to the tagger.
`timescale 1ns/1ps
`include "batch_stream_defines.svh"

module moderating_fifo (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     tag_valid,
    input  stream_beat_pkg::sample_t tag_data,
    input  stream_beat_pkg::dest_t   tag_dest,
    input  stream_beat_pkg::seq_t    tag_user,
    input  logic                     tag_last,
    output logic                     tag_credit,
    output logic                     rel_valid,
    output stream_beat_pkg::sample_t rel_data,
    output stream_beat_pkg::dest_t   rel_dest,
    output stream_beat_pkg::seq_t    rel_user,
    output logic                     rel_last,
    input  logic                     rel_credit
);
    import stream_beat_pkg::*;
    import stream_ctrl_pkg::*;

    fifo_phase_e   phase;
    // Beats currently stored
    fill_count_t   fill_count;
    // Beats already released in the current batch
    fill_count_t   sent_count;
    fifo_addr_t    wr_ptr;
    fifo_addr_t    rd_ptr;
    // Credits held toward the sender buffer
    credit_count_t send_credits;
    logic          send;
    logic          batch_done;

    sample_t data_mem [`FIFO_DEPTH];
    dest_t   dest_mem [`FIFO_DEPTH];
    seq_t    user_mem [`FIFO_DEPTH];
    logic    last_mem [`FIFO_DEPTH];

    // Pointer step with an explicit wrap, so any depth works
    function automatic fifo_addr_t next_addr(input fifo_addr_t addr);
        if (addr == fifo_addr_t'(`FIFO_DEPTH - 1)) begin
            return '0;
        end
        return addr + fifo_addr_t'(1);
    endfunction

    // A beat leaves only in release and only with sender credit in hand
    assign send       = (phase == phase_release) && (send_credits != '0);
    assign batch_done = send && (sent_count == fill_count_t'(`BATCH_LEN - 1));

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            phase        <= phase_collect;
            fill_count   <= '0;
            sent_count   <= '0;
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            send_credits <= credit_count_t'(`SENDER_SLOTS);
            rel_valid    <= 1'b0;
            tag_credit   <= 1'b0;
        end else begin
            rel_valid    <= send;
            // The freed slot goes back to the tagger as a credit
            tag_credit   <= send;
            send_credits <= send_credits + credit_count_t'(rel_credit)
                            - credit_count_t'(send);
            // Writes are taken in both phases
            fill_count   <= fill_count + fill_count_t'(tag_valid) - fill_count_t'(send);
            if (tag_valid) begin
                wr_ptr <= next_addr(wr_ptr);
            end
            if (send) begin
                rd_ptr <= next_addr(rd_ptr);
            end
            case (phase)
                phase_collect: begin
                    if (fill_count >= fill_count_t'(`BATCH_LEN)) begin
                        phase <= phase_release;
                    end
                end
                phase_release: begin
                    // Without sender credit the batch simply pauses here
                    if (batch_done) begin
                        sent_count <= '0;
                        phase      <= phase_collect;
                    end else if (send) begin
                        sent_count <= sent_count + fill_count_t'(1);
                    end
                end
                default: begin
                    phase <= phase_collect;
                end
            endcase
        end
    end

    // Storage for all four beat fields
    always_ff @(posedge clock) begin
        if (tag_valid) begin
            data_mem[wr_ptr] <= tag_data;
            dest_mem[wr_ptr] <= tag_dest;
            user_mem[wr_ptr] <= tag_user;
            last_mem[wr_ptr] <= tag_last;
        end
    end

    // Registered release beat, read from the oldest slot
    always_ff @(posedge clock) begin
        if (send) begin
            rel_data <= data_mem[rd_ptr];
            rel_dest <= dest_mem[rd_ptr];
            rel_user <= user_mem[rd_ptr];
            rel_last <= last_mem[rd_ptr];
        end
    end

endmodule

//--- sample_tagger.sv
// Entry stage of the batch stream path.
// Stamps each converter sample with its channel, a sequence number and a
// packet end flag, and spends one FIFO credit per beat. The converter has
// no flow control, so a sample that finds no credit is dropped and counted.
`timescale 1ns/1ps
`include "batch_stream_defines.svh"

module sample_tagger (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         sample_valid,
    input  stream_beat_pkg::sample_t     sample,
    input  stream_beat_pkg::dest_t       channel,
    input  logic                         tag_credit,
    output logic                         tag_valid,
    output stream_beat_pkg::sample_t     tag_data,
    output stream_beat_pkg::dest_t       tag_dest,
    output stream_beat_pkg::seq_t        tag_user,
    output logic                         tag_last,
    output stream_ctrl_pkg::drop_count_t drop_count
);
    import stream_beat_pkg::*;
    import stream_ctrl_pkg::*;

    // Credits still available toward the FIFO
    credit_count_t credits;
    // Number that the next accepted sample takes
    seq_t          seq;
    // Position of the next accepted sample within its packet
    packet_pos_t   packet_pos;
    logic          credit_held;
    logic          accept;
    logic          packet_end;

    // A credit pulse arriving with a sample is counted first
    assign credit_held = (credits != '0) || tag_credit;
    assign accept      = sample_valid && credit_held;
    assign packet_end  = (packet_pos == packet_pos_t'(`PACKET_LEN - 1));

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            credits    <= credit_count_t'(`FIFO_DEPTH);
            seq        <= '0;
            packet_pos <= '0;
            tag_valid  <= 1'b0;
            drop_count <= '0;
        end else begin
            // One credit comes back per pulse and one leaves per beat
            credits   <= credits + credit_count_t'(tag_credit) - credit_count_t'(accept);
            tag_valid <= accept;
            if (accept) begin
                seq <= seq + seq_t'(1);
                if (packet_end) begin
                    packet_pos <= '0;
                end else begin
                    packet_pos <= packet_pos + packet_pos_t'(1);
                end
            end
            // Dropped samples take no number, the counter holds at its top
            if (sample_valid && !accept && (drop_count != '1)) begin
                drop_count <= drop_count + drop_count_t'(1);
            end
        end
    end

    // Beat fields, loaded only for accepted samples
    always_ff @(posedge clock) begin
        if (accept) begin
            tag_data <= sample;
            tag_dest <= channel;
            tag_user <= seq;
            tag_last <= packet_end;
        end
    end

endmodule

//--- stream_beat_pkg.sv
// Types of the fields that make up one beat of the stream.
// Every link in the path carries these three vectors next to its
// valid and last bits, so all modules share them from here.
`include "batch_stream_defines.svh"

package stream_beat_pkg;

    // Raw converter sample as it travels through the path
    typedef logic [`DATA_W-1:0] sample_t;

    // Destination channel stamped by the tagger
    typedef logic [`DEST_W-1:0] dest_t;

    // Sequence number held in the user field
    // It wraps silently once it runs past its width
    typedef logic [`USER_W-1:0] seq_t;

endpackage

//--- stream_ctrl_pkg.sv
// Control types of the batch stream path: the FIFO phase, the counters
// and the addresses of the internal buffers.
`include "batch_stream_defines.svh"

package stream_ctrl_pkg;

    // Largest credit pool on any link in the path
    localparam int CREDIT_MAX =
        (`FIFO_DEPTH > `SINK_CREDITS) ?
        ((`FIFO_DEPTH > `SENDER_SLOTS) ? `FIFO_DEPTH : `SENDER_SLOTS) :
        ((`SINK_CREDITS > `SENDER_SLOTS) ? `SINK_CREDITS : `SENDER_SLOTS);

    // The FIFO either gathers beats or drains one batch
    typedef enum logic {
        phase_collect,
        phase_release
    } fifo_phase_e;

    typedef logic [$clog2(`FIFO_DEPTH+1)-1:0] fill_count_t;
    typedef logic [$clog2(`FIFO_DEPTH)-1:0]   fifo_addr_t;
    typedef logic [$clog2(`SENDER_SLOTS)-1:0] slot_addr_t;
    typedef logic [$clog2(`PACKET_LEN)-1:0]   packet_pos_t;
    typedef logic [$clog2(CREDIT_MAX+1)-1:0]  credit_count_t;
    typedef logic [15:0]                      drop_count_t;

endpackage

//--- tb_batch_stream_top.sv
// Testbench for the batch stream path.
// Offers random samples with no flow control, models a sink that returns
// each credit after a random delay, and rebuilds the expected output stream
// from the offered samples and the growth of drop_count.
`timescale 1ns/1ps
`include "batch_stream_defines.svh"

module tb_batch_stream_top;
    import stream_beat_pkg::*;
    import stream_ctrl_pkg::*;

    localparam int RAND_CYCLES  = 1500;
    localparam int STALL_CYCLES = 200;
    localparam int WAIT_LIMIT   = 2000;

    logic        clock;
    logic        rst_n;
    logic        sample_valid;
    sample_t     sample;
    dest_t       channel;
    logic        out_credit;
    logic        out_valid;
    sample_t     out_data;
    dest_t       out_dest;
    seq_t        out_user;
    logic        out_last;
    drop_count_t drop_count;

    // Accepted samples not yet seen at the output in arrival order
    sample_t     exp_data[$];
    dest_t       exp_dest[$];
    // Cycle in which the sink hands back each outstanding credit
    int          credit_due[$];
    int          cycle;
    int          offered;
    int          accepted;
    int          out_count;
    int          outstanding;
    int          stall_beats;
    int          errors;
    int          prop_errors;
    int          wait_count;
    // Sample offered last cycle whose fate shows in drop_count now
    logic        pending;
    sample_t     pend_data;
    dest_t       pend_dest;
    drop_count_t last_drops;
    seq_t        next_user;
    logic        sink_paused;
    logic        timed_out;

    batch_stream_top dut0 (.*);

    // Credit and phase properties on the FIFO and the sender
    bind moderating_fifo batch_stream_props #(.POOL(`SENDER_SLOTS), .BATCH(`BATCH_LEN)) fifo_props (
        .clock(clock), .rst_n(rst_n), .credits(send_credits), .spend(send),
        .credit_back(rel_credit), .in_release(phase == stream_ctrl_pkg::phase_release)
    );
    bind credit_sender batch_stream_props #(.POOL(`SINK_CREDITS)) sender_props (
        .clock(clock), .rst_n(rst_n), .credits(sink_credits), .spend(send),
        .credit_back(out_credit), .in_release(1'b0)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] got);
        errors++;
        $display("** Error %s: expected %h, got %h", name, expected, got);
    endtask

    task automatic report_text(input string msg);
        errors++;
        $display("Error at cycle %0d: %s", cycle, msg);
    endtask

    task automatic check_beat();
        logic want_last;
        want_last = (int'(next_user) % `PACKET_LEN) == `PACKET_LEN - 1;
        out_count++;
        outstanding++;
        credit_due.push_back(cycle + int'($urandom_range(6, 1)));
        if (sink_paused) begin
            stall_beats++;
        end
        assert (out_user == next_user) else report_value("out_user", next_user, out_user);
        assert (out_last == want_last) else report_value("out_last", want_last, out_last);
        assert (outstanding <= `SINK_CREDITS) else
            report_text($sformatf("the sink holds %0d beats, more than its credits", outstanding));
        // Only whole batches may have left the FIFO so far
        assert (out_count <= (accepted / `BATCH_LEN) * `BATCH_LEN) else
            report_text("a beat left before its batch was complete");
        assert (exp_data.size() > 0) else
            report_text("an output beat arrived with no accepted sample left to match");
        if (exp_data.size() > 0) begin
            assert (out_data == exp_data[0]) else report_value("out_data", exp_data[0], out_data);
            assert (out_dest == exp_dest[0]) else report_value("out_dest", exp_dest[0], out_dest);
            void'(exp_data.pop_front());
            void'(exp_dest.pop_front());
        end
        next_user++;
    endtask

    task automatic observe_outputs();
        int grown;
        grown = int'(drop_count) - int'(last_drops);
        if (pending && grown == 1) begin
            // The occupancy mirror must show a full FIFO for a drop to be legal
            assert (accepted - out_count >= `FIFO_DEPTH) else
                report_text($sformatf("sample dropped with only %0d beats held",
                                      accepted - out_count));
        end else if (pending) begin
            assert (grown == 0) else report_value("drop_count", last_drops + 1, drop_count);
            exp_data.push_back(pend_data);
            exp_dest.push_back(pend_dest);
            accepted++;
        end else begin
            assert (grown == 0) else report_value("drop_count", last_drops, drop_count);
        end
        last_drops = drop_count;
        pending    = 1'b0;
        if (out_valid) begin
            check_beat();
        end
    endtask

    task automatic drive_inputs(input logic offer);
        int found;
        found        = -1;
        sample_valid = offer;
        sample       = sample_t'($urandom);
        channel      = dest_t'($urandom);
        if (offer) begin
            pending   = 1'b1;
            pend_data = sample;
            pend_dest = channel;
            offered++;
        end
        // The sink returns at most one due credit per cycle
        foreach (credit_due[i]) begin
            if (found < 0 && credit_due[i] <= cycle) begin
                found = i;
            end
        end
        out_credit = 1'b0;
        if (!sink_paused && found >= 0) begin
            credit_due.delete(found);
            out_credit = 1'b1;
            outstanding--;
        end
    endtask

    // Outputs are read and inputs driven 1 ns after the rising edge
    task automatic run_cycle(input logic offer);
        @(posedge clock);
        #1;
        cycle++;
        observe_outputs();
        drive_inputs(offer);
    endtask

    task automatic run_random(input int cycles);
        repeat (cycles) begin
            run_cycle($urandom_range(99) < 60);
        end
    endtask

    initial begin
        void'($urandom(29742));
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample       = '0;
        channel      = '0;
        out_credit   = 1'b0;
        cycle        = 0;
        offered      = 0;
        accepted     = 0;
        out_count    = 0;
        outstanding  = 0;
        stall_beats  = 0;
        errors       = 0;
        prop_errors  = 0;
        pending      = 1'b0;
        last_drops   = '0;
        next_user    = '0;
        sink_paused  = 1'b0;
        timed_out    = 1'b0;
        repeat (5) @(posedge clock);
        #1;
        rst_n = 1'b1;
        assert (out_valid == 1'b0) else report_value("out_valid", 0, out_valid);
        assert (drop_count == '0) else report_value("drop_count", 0, drop_count);
        run_random(RAND_CYCLES);
        // The sink withholds every credit, so the FIFO fills and samples drop
        sink_paused = 1'b1;
        run_random(STALL_CYCLES);
        sink_paused = 1'b0;
        assert (stall_beats <= `SINK_CREDITS) else
            report_text($sformatf("%0d beats left while the sink was stalled", stall_beats));
        run_random(RAND_CYCLES);
        run_cycle(1'b0);
        // Single samples until the accepted count ends on a batch boundary
        wait_count = 0;
        while (!timed_out && (accepted % `BATCH_LEN) != 0) begin
            run_cycle(1'b1);
            run_cycle(1'b0);
            wait_count++;
            if (wait_count > WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("Timeout: the flush never reached a batch boundary");
            end
        end
        wait_count = 0;
        while (!timed_out && out_count < accepted) begin
            run_cycle(1'b0);
            wait_count++;
            if (wait_count > WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("Timeout: accepted samples never all reached the output");
            end
        end
        // Quiet tail that would expose a stray beat
        repeat (20) run_cycle(1'b0);
        assert (accepted + int'(drop_count) == offered) else
            report_value("accepted + drop_count", offered, accepted + int'(drop_count));
        assert (out_count == accepted) else report_value("output beat count", accepted, out_count);
        prop_errors = dut0.u_fifo.fifo_props.fail_count + dut0.u_sender.sender_props.fail_count;
        $display("Beats out: %0d  Drops: %0d  Errors: %0d  Property failures: %0d",
                 out_count, drop_count, errors, prop_errors);
        if (errors == 0 && prop_errors == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
